/* motorGateDrive.sv */
`timescale 1ns/10ps

module motorGateDrive
    import motorPwmPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  stepIdx_t             stepIdx,
    input  logic                 pwmA,
    input  logic                 pwmB,
    input  logic                 pwmC,
    input  pwmCount_t            deadTime,
    output logic [numPhases-1:0] gateHigh,
    output logic [numPhases-1:0] gateLow
);

    logic [numPhases-1:0]   pwmVec;
    // high gates in the lower half, low gates in the upper half
    logic [2*numPhases-1:0] wantOn;
    wire  [2*numPhases-1:0] gateOn;

    assign pwmVec = {pwmC, pwmB, pwmA};

    always_comb begin
        for (int k = 0; k < numPhases; k++) begin
            stepIdx_t phaseStep;
            phaseStep = localStep(stepIdx, k * phaseStride);
            wantOn[k]             = pwmVec[k] && isHighStep(phaseStep);
            wantOn[k + numPhases] = pwmVec[k] && isLowStep(phaseStep);
        end
    end

    // every gate waits deadTime cycles before it turns on, turn-off is immediate
    for (genvar g = 0; g < 2 * numPhases; g++) begin : gGate
        pwmCount_t deadCnt;
        logic      gateReg;

        always_ff @(negedge clk or negedge arstN) begin
            if (!arstN) begin
                deadCnt <= '0;
                gateReg <= 1'b0;
            end else if (!wantOn[g]) begin
                deadCnt <= '0;
                gateReg <= 1'b0;
            end else if (deadCnt >= deadTime) begin
                gateReg <= 1'b1;
            end else begin
                deadCnt <= deadCnt + 1'b1;
            end
        end

        assign gateOn[g] = gateReg;
    end

    assign gateHigh = gateOn[numPhases-1:0];
    assign gateLow  = gateOn[2*numPhases-1:numPhases];

endmodule

/* motorPhasePwm.sv */
`timescale 1ns/10ps

module motorPhasePwm
    import motorPwmPkg::*;
#(
    parameter int phaseOffset = 0
) (
    input  logic      clk,
    input  logic      arstN,
    input  stepIdx_t  stepIdx,
    input  logic      stepFirst,
    input  logic      stepLast,
    input  pwmCount_t pwmLen,
    input  pwmCount_t duty,
    input  pwmCount_t minPulse,
    output logic      pwm,
    output posCount_t lost
);

    stepIdx_t    phaseStep;
    logic        active;
    logic        inStep;
    logic        periodStart;
    logic        remainClear;
    pwmCount_t   periodCnt;
    posCount_t   remain;
    posCount_t   sum;
    posCount_t   pulseCnt;
    posCount_t   wantAcc;
    posCount_t   realAcc;
    posCount_t   diff;
    skipReason_t skip;

    assign phaseStep = localStep(stepIdx, phaseOffset);
    assign active    = isHighStep(phaseStep) || isLowStep(phaseStep);

    // a step always opens a new period, later ones follow every pwmLen cycles
    assign periodStart = stepFirst || (inStep && (periodCnt == pwmCount_t'(1)));

    // the remainder never crosses from the high half to the low half
    assign remainClear = stepLast && ((phaseStep == stepIdx_t'(hiStepLast)) ||
                                      (phaseStep == stepIdx_t'(loStepLast)));

    assign sum = remain + posCount_t'(duty);

    always_comb begin
        if (!active) begin
            skip = noActive;
        end else if (sum < posCount_t'(minPulse)) begin
            skip = minLimit;
        end else begin
            skip = noSkip;
        end
    end

    // pulses are cut in the last cycle of a step so the gate is off by the next one
    assign pwm = (pulseCnt != '0) && !stepLast;

    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            inStep <= 1'b0;
        end else if (stepLast) begin
            inStep <= 1'b0;
        end else if (stepFirst) begin
            inStep <= 1'b1;
        end
    end

    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            periodCnt <= '0;
        end else if (periodStart) begin
            periodCnt <= pwmLen;
        end else if (periodCnt != '0) begin
            periodCnt <= periodCnt - 1'b1;
        end
    end

    // too short a pulse is not worth switching the bridge, its width waits here
    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            remain <= '0;
        end else if (remainClear) begin
            remain <= '0;
        end else if (periodStart) begin
            case (skip)
                noSkip:   remain <= '0;
                minLimit: remain <= sum;
                default:  ;
            endcase
        end
    end

    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            pulseCnt <= '0;
        end else if (stepLast) begin
            pulseCnt <= '0;
        end else if (periodStart && (skip == noSkip)) begin
            pulseCnt <= sum;
        end else if (pulseCnt != '0) begin
            pulseCnt <= pulseCnt - 1'b1;
        end
    end

    // wanted width of the running step, duty for every period it opened
    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            wantAcc <= '0;
        end else if (stepFirst) begin
            wantAcc <= active ? posCount_t'(duty) : '0;
        end else if (periodStart && active) begin
            wantAcc <= wantAcc + posCount_t'(duty);
        end
    end

    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            realAcc <= '0;
        end else if (stepFirst) begin
            realAcc <= posCount_t'(pwm);
        end else if (pwm) begin
            realAcc <= realAcc + 1'b1;
        end
    end

    // carried remainder can deliver more than was wanted in a step, so keep the size only
    assign diff = wantAcc - realAcc;

    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            lost <= '0;
        end else if (stepFirst) begin
            lost <= diff[$bits(posCount_t)-1] ? posCount_t'(-diff) : diff;
        end
    end

endmodule

/* motorPwmPkg.sv */
package motorPwmPkg;

    localparam int numPhases = 3;
    localparam int numSteps  = 12;

    // phase k runs its own sequence shifted by k times this many steps
    localparam int phaseStride = 4;

    // local steps in which a phase switches its high or its low side
    localparam int hiStepFirst = 0;
    localparam int hiStepLast  = 3;
    localparam int loStepFirst = 6;
    localparam int loStepLast  = 9;

    typedef logic [3:0]  stepIdx_t;
    typedef logic [11:0] pwmCount_t;
    typedef logic [15:0] posCount_t;
    typedef logic [15:0] stepLen_t;

    // outcome of the decision taken at each period start
    typedef enum logic [1:0] {
        noActive,
        minLimit,
        noSkip
    } skipReason_t;

    // global step seen from a phase that lags by offset steps
    function automatic stepIdx_t localStep(input stepIdx_t step, input int offset);
        int shifted;
        shifted = int'(step) + numSteps - offset;
        if (shifted >= numSteps) begin
            shifted = shifted - numSteps;
        end
        return stepIdx_t'(shifted);
    endfunction

    function automatic logic isHighStep(input stepIdx_t step);
        return step inside {[hiStepFirst:hiStepLast]};
    endfunction

    function automatic logic isLowStep(input stepIdx_t step);
        return step inside {[loStepFirst:loStepLast]};
    endfunction

endpackage

/* motorPwmStimulus.txt */
// one test per line, all values in hex
// stepLen pwmLen duty minPulse deadTime steps expEdges expLost
// plain pulses, every period delivers its full width
64 14 8 4 2 d 5 0
// last pulse of each step is clipped at the step end
64 1e 14 4 3 d 4 c
// duty below the minimum pulse, width carried in the remainder
78 14 3 a 1 d 1 6
// pulses shorter than the dead time never reach the gate
64 19 5 7 a d 0 0

/* motorPwmTop.f */
motorPwmPkg.sv
motorRegPkg.sv
motorRegFile.sv
motorStepSequencer.sv
motorPhasePwm.sv
motorGateDrive.sv
motorPwmTop.sv
tbMotorPwm.sv

/* motorPwmTop.sv */
`timescale 1ns/10ps

module motorPwmTop
    import motorPwmPkg::*, motorRegPkg::*;
(
    input  logic                 clk,
    input  logic                 arstN,
    input  regAddr_t             awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  dataWord_t            wdata,
    input  strobe_t              wstrb,
    input  logic                 wvalid,
    output logic                 wready,
    output axiResp_t             bresp,
    output logic                 bvalid,
    input  logic                 bready,
    input  regAddr_t             araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output dataWord_t            rdata,
    output axiResp_t             rresp,
    output logic                 rvalid,
    input  logic                 rready,
    output logic [numPhases-1:0] gateHigh,
    output logic [numPhases-1:0] gateLow,
    output stepIdx_t             stepIdx
);

    logic                 run;
    stepLen_t             stepLen;
    pwmCount_t            pwmLen;
    pwmCount_t            duty;
    pwmCount_t            minPulse;
    pwmCount_t            deadTime;
    logic                 stepFirst;
    logic                 stepLast;
    logic [numPhases-1:0] pwm;
    posCount_t            lost [numPhases];

    motorRegFile i_regFile (
        .clk      (clk),      .arstN    (arstN),
        .awaddr   (awaddr),   .awvalid  (awvalid),  .awready (awready),
        .wdata    (wdata),    .wstrb    (wstrb),    .wvalid  (wvalid),   .wready (wready),
        .bresp    (bresp),    .bvalid   (bvalid),   .bready  (bready),
        .araddr   (araddr),   .arvalid  (arvalid),  .arready (arready),
        .rdata    (rdata),    .rresp    (rresp),    .rvalid  (rvalid),   .rready (rready),
        .run      (run),      .stepLen  (stepLen),  .pwmLen  (pwmLen),
        .duty     (duty),     .minPulse (minPulse), .deadTime(deadTime),
        .lostA    (lost[0]),  .lostB    (lost[1]),  .lostC   (lost[2])
    );

    motorStepSequencer i_sequencer (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .stepLen   (stepLen),
        .stepIdx   (stepIdx),
        .stepFirst (stepFirst),
        .stepLast  (stepLast)
    );

    // phase k lags the sequence by k * phaseStride steps
    for (genvar k = 0; k < numPhases; k++) begin : gPhase
        motorPhasePwm #(
            .phaseOffset (k * phaseStride)
        ) i_phase (
            .clk       (clk),       .arstN    (arstN),
            .stepIdx   (stepIdx),   .stepFirst(stepFirst), .stepLast(stepLast),
            .pwmLen    (pwmLen),    .duty     (duty),      .minPulse(minPulse),
            .pwm       (pwm[k]),    .lost     (lost[k])
        );
    end

    motorGateDrive i_gateDrive (
        .clk      (clk),
        .arstN    (arstN),
        .stepIdx  (stepIdx),
        .pwmA     (pwm[0]),
        .pwmB     (pwm[1]),
        .pwmC     (pwm[2]),
        .deadTime (deadTime),
        .gateHigh (gateHigh),
        .gateLow  (gateLow)
    );

endmodule

/* motorRegFile.sv */
`timescale 1ns/10ps

module motorRegFile
    import motorPwmPkg::*, motorRegPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  regAddr_t  awaddr,
    input  logic      awvalid,
    output logic      awready,
    input  dataWord_t wdata,
    input  strobe_t   wstrb,
    input  logic      wvalid,
    output logic      wready,
    output axiResp_t  bresp,
    output logic      bvalid,
    input  logic      bready,
    input  regAddr_t  araddr,
    input  logic      arvalid,
    output logic      arready,
    output dataWord_t rdata,
    output axiResp_t  rresp,
    output logic      rvalid,
    input  logic      rready,
    output logic      run,
    output stepLen_t  stepLen,
    output pwmCount_t pwmLen,
    output pwmCount_t duty,
    output pwmCount_t minPulse,
    output pwmCount_t deadTime,
    input  posCount_t lostA,
    input  posCount_t lostB,
    input  posCount_t lostC
);

    typedef enum logic {
        respIdle,
        respBusy
    } respState_t;

    respState_t wrState;
    respState_t rdState;
    logic       wrAccept;
    logic       rdAccept;
    dataWord_t  curWord;
    dataWord_t  mergedWord;

    // current content of a register as seen on the bus, zero when unmapped
    function automatic dataWord_t regValue(input regAddr_t addr);
        dataWord_t value;
        value = '0;
        case (addr)
            regCtrl:     value[0]     = run;
            regStepLen:  value[15:0]  = stepLen;
            regPwmLen:   value[11:0]  = pwmLen;
            regDuty:     value[11:0]  = duty;
            regMinPulse: value[11:0]  = minPulse;
            regDeadTime: value[11:0]  = deadTime;
            regLostA:    value[15:0]  = lostA;
            regLostB:    value[15:0]  = lostB;
            regLostC:    value[15:0]  = lostC;
            default:     value        = '0;
        endcase
        return value;
    endfunction

    // address and data are taken in the same beat, never one without the other
    assign awready  = (wrState == respIdle) && wvalid;
    assign wready   = (wrState == respIdle) && awvalid;
    assign wrAccept = (wrState == respIdle) && awvalid && wvalid;
    assign bvalid   = (wrState == respBusy);
    assign bresp    = respOkay;

    assign arready  = (rdState == respIdle);
    assign rdAccept = arvalid && arready;
    assign rvalid   = (rdState == respBusy);
    assign rresp    = respOkay;

    // bytes without a strobe keep their old value
    always_comb begin
        curWord = regValue(awaddr);
        for (int b = 0; b < axiStrbWidth; b++) begin
            mergedWord[b*8 +: 8] = wstrb[b] ? wdata[b*8 +: 8] : curWord[b*8 +: 8];
        end
    end

    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            wrState <= respIdle;
        end else if (wrAccept) begin
            wrState <= respBusy;
        end else if (bready) begin
            wrState <= respIdle;
        end
    end

    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            rdState <= respIdle;
        end else if (rdAccept) begin
            rdState <= respBusy;
        end else if (rready) begin
            rdState <= respIdle;
        end
    end

    always_ff @(negedge clk) begin
        if (rdAccept) begin
            rdata <= regValue(araddr);
        end
    end

    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            run      <= rstCtrl[0];
            stepLen  <= rstStepLen[15:0];
            pwmLen   <= rstPwmLen[11:0];
            duty     <= rstDuty[11:0];
            minPulse <= rstMinPulse[11:0];
            deadTime <= rstDeadTime[11:0];
        end else if (wrAccept) begin
            case (awaddr)
                regCtrl:     run      <= mergedWord[0];
                regStepLen:  stepLen  <= mergedWord[15:0];
                regPwmLen:   pwmLen   <= mergedWord[11:0];
                regDuty:     duty     <= mergedWord[11:0];
                regMinPulse: minPulse <= mergedWord[11:0];
                regDeadTime: deadTime <= mergedWord[11:0];
                default:     ;
            endcase
        end
    end

endmodule

/* motorRegPkg.sv */
package motorRegPkg;

    localparam int axiAddrWidth = 6;
    localparam int axiDataWidth = 32;
    localparam int axiStrbWidth = axiDataWidth / 8;

    typedef logic [axiAddrWidth-1:0] regAddr_t;
    typedef logic [axiDataWidth-1:0] dataWord_t;
    typedef logic [axiStrbWidth-1:0] strobe_t;
    typedef logic [1:0]              axiResp_t;

    localparam axiResp_t respOkay = 2'b00;

    // byte offsets of the 32-bit registers
    localparam regAddr_t regCtrl     = 6'h00;
    localparam regAddr_t regStepLen  = 6'h04;
    localparam regAddr_t regPwmLen   = 6'h08;
    localparam regAddr_t regDuty     = 6'h0C;
    localparam regAddr_t regMinPulse = 6'h10;
    localparam regAddr_t regDeadTime = 6'h14;
    // loss magnitudes of the three phases, read only
    localparam regAddr_t regLostA    = 6'h18;
    localparam regAddr_t regLostB    = 6'h1C;
    localparam regAddr_t regLostC    = 6'h20;

    // values after reset, the motor stays stopped until run is written
    localparam dataWord_t rstCtrl     = 32'd0;
    localparam dataWord_t rstStepLen  = 32'd240;
    localparam dataWord_t rstPwmLen   = 32'd40;
    localparam dataWord_t rstDuty     = 32'd10;
    localparam dataWord_t rstMinPulse = 32'd4;
    localparam dataWord_t rstDeadTime = 32'd2;

endpackage

/* motorStepSequencer.sv */
`timescale 1ns/10ps

module motorStepSequencer
    import motorPwmPkg::*;
(
    input  logic     clk,
    input  logic     arstN,
    input  logic     run,
    input  stepLen_t stepLen,
    output stepIdx_t stepIdx,
    output logic     stepFirst,
    output logic     stepLast
);

    logic                     running;
    stepLen_t                 cycleCnt;
    logic [$bits(stepLen_t):0] cycleNext;
    logic                     lastCycle;

    // one bit wider so that a step length of zero behaves like one
    assign cycleNext = {1'b0, cycleCnt} + 1'b1;
    assign lastCycle = (cycleNext >= {1'b0, stepLen});

    assign stepFirst = running && run && (cycleCnt == '0);

    // dropping run ends the current step at once so the phases close their pulses
    assign stepLast = running && (lastCycle || !run);

    always_ff @(negedge clk or negedge arstN) begin
        if (!arstN) begin
            running  <= 1'b0;
            cycleCnt <= '0;
            stepIdx  <= '0;
        end else if (!run || !running) begin
            // idle, or the first cycle after run was seen high
            running  <= run;
            cycleCnt <= '0;
            stepIdx  <= '0;
        end else if (lastCycle) begin
            cycleCnt <= '0;
            if (stepIdx == stepIdx_t'(numSteps - 1)) begin
                stepIdx <= '0;
            end else begin
                stepIdx <= stepIdx + 1'b1;
            end
        end else begin
            cycleCnt <= cycleCnt + 1'b1;
        end
    end

endmodule

/* tbMotorPwm.sv */
`timescale 1ns/10ps

module tbMotorPwm;

    localparam int numTests      = 4;
    localparam int fieldsPerTest = 8;
    localparam int marginPerTest = 600;

    logic        clk;
    logic        arstN;
    logic [5:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [5:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [2:0]  gateHigh;
    logic [2:0]  gateLow;
    logic [3:0]  stepIdx;

    logic [31:0] stim [numTests*fieldsPerTest];
    int          seed;
    int          errors;
    int          checks;
    int          cycleCount;
    int          cycleLimit;
    logic        monEn;
    logic        edgeEn;
    logic        seenChange;
    logic [3:0]  prevIdx;
    logic [2:0]  prevHigh;
    logic [2:0]  prevLow;
    int          stepChanges;
    int          stepCycles;
    int          curStepLen;
    int          edgesHigh;
    int          edgesLow;

    motorPwmTop i_dut (
        .clk(clk), .arstN(arstN),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .gateHigh(gateHigh), .gateLow(gateLow), .stepIdx(stepIdx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic compareValue(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic applyReset();
        arstN <= 1'b0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        @(posedge clk);
        compareValue({bvalid, rvalid, gateHigh, gateLow}, 0, "outputs after reset");
    endtask

    task automatic writeReg(input logic [5:0] addr, input logic [31:0] data);
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hF;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do @(posedge clk); while (!bvalid);
        // both valids are still high here and the readies must stay low until the response is taken
        compareValue(awready, 0, "awready with a write response pending");
        compareValue(wready, 0, "wready with a write response pending");
        compareValue(bresp, 0, "write response code");
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (bvalid);
    endtask

    task automatic readReg(input logic [5:0] addr, output logic [31:0] data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        compareValue(arready, 0, "arready with a read response pending");
        compareValue(rresp, 0, "read response code");
        arvalid <= 1'b0;
        do @(posedge clk); while (rvalid);
    endtask

    task automatic readCheck(input logic [5:0] addr, input int exp, input string what);
        logic [31:0] value;
        readReg(addr, value);
        compareValue(value, exp, what);
    endtask

    // width lost and gate edges of a phase in its first active step, remainder starting empty
    task automatic modelStep(input int sl, input int pl, input int du, input int mp,
                             input int dt, output int lostOut, output int edgesOut);
        int rem;
        int want;
        int got;
        int sum;
        int len;
        rem = 0;
        want = 0;
        got = 0;
        edgesOut = 0;
        for (int s = 0; s < sl; s += pl) begin
            want += du;
            sum = rem + du;
            if (sum < mp) begin
                rem = sum;
            end else begin
                // the pulse runs from s+1 and must end before the last cycle of the step
                len = (s + sum > sl - 2) ? sl - 2 - s : sum;
                if (len < 0) len = 0;
                got += len;
                if (len >= dt + 1) edgesOut++;
                rem = 0;
            end
        end
        lostOut = (want > got) ? want - got : got - want;
    endtask

    // random back-pressure on both response channels
    always @(posedge clk) begin
        bready <= ($random(seed) & 3) != 0;
        rready <= ($random(seed) & 3) != 0;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycleCount);
            $display("TEST FAIL");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (arstN) begin
            for (int k = 0; k < 3; k++) begin
                int ls;
                ls = (int'(stepIdx) + 12 - 4 * k) % 12;
                if (gateHigh[k] && gateLow[k]) begin
                    $display("both gates of phase %0d high at %0t ns", k, $time);
                    errors++;
                end
                if ((gateHigh[k] && ls > 3) || (gateLow[k] && (ls < 6 || ls > 9))) begin
                    $display("gate of phase %0d on in idle local step %0d", k, ls);
                    errors++;
                end
            end
        end
        if (edgeEn) begin
            if (stepIdx == 4'd1) begin
                edgeEn = 1'b0;
            end else begin
                if (gateHigh[0] && !prevHigh[0]) edgesHigh++;
                if (gateLow[1] && !prevLow[1]) edgesLow++;
            end
        end
        if (monEn) begin
            if (stepIdx != prevIdx) begin
                if (seenChange) begin
                    compareValue(stepCycles, curStepLen, "step length");
                end
                compareValue(stepIdx, (int'(prevIdx) + 1) % 12, "next step index");
                seenChange = 1'b1;
                stepChanges++;
                stepCycles = 1;
            end else begin
                stepCycles++;
            end
        end
        prevIdx  = stepIdx;
        prevHigh = gateHigh;
        prevLow  = gateLow;
    end

    initial begin
        int base;
        int modelLost;
        int modelEdges;
        int failsBefore;
        int testsRun;
        seed = 8844;
        errors = 0;
        checks = 0;
        testsRun = 0;
        cycleCount = 0;
        cycleLimit = 20000;
        arstN = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        monEn = 1'b0;
        edgeEn = 1'b0;
        seenChange = 1'b0;
        $readmemh("motorPwmStimulus.txt", stim);
        if ($isunknown(stim[0])) begin
            $display("stimulus file motorPwmStimulus.txt could not be read");
            errors++;
        end else begin
            cycleLimit = 0;
            for (int t = 0; t < numTests; t++) begin
                cycleLimit += stim[t*fieldsPerTest+5] * stim[t*fieldsPerTest] + marginPerTest;
            end
            for (int t = 0; t < numTests; t++) begin
                base = t * fieldsPerTest;
                failsBefore = errors;
                modelStep(stim[base], stim[base+1], stim[base+2], stim[base+3], stim[base+4],
                          modelLost, modelEdges);
                compareValue(modelLost, stim[base+7], "model lost against file");
                compareValue(modelEdges, stim[base+6], "model edges against file");
                applyReset();
                writeReg(6'h04, stim[base]);
                writeReg(6'h08, stim[base+1]);
                writeReg(6'h0C, stim[base+2]);
                writeReg(6'h10, stim[base+3]);
                writeReg(6'h14, stim[base+4]);
                readCheck(6'h04, stim[base], "stepLen readback");
                readCheck(6'h08, stim[base+1], "pwmLen readback");
                readCheck(6'h0C, stim[base+2], "duty readback");
                readCheck(6'h10, stim[base+3], "minPulse readback");
                readCheck(6'h14, stim[base+4], "deadTime readback");
                readCheck(6'h3C, 0, "unknown address readback");
                curStepLen = stim[base];
                stepChanges = 0;
                seenChange = 1'b0;
                edgesHigh = 0;
                edgesLow = 0;
                edgeEn = 1'b1;
                monEn = 1'b1;
                writeReg(6'h00, 32'd1);
                readCheck(6'h00, 1, "ctrl readback");
                // step 0 is over, phase A and phase B hold the loss of their first active step
                do @(posedge clk); while (stepIdx != 4'd1);
                readCheck(6'h18, stim[base+7], "lostA");
                readCheck(6'h1C, stim[base+7], "lostB");
                readCheck(6'h20, 0, "lostC");
                compareValue(edgesHigh, stim[base+6], "phase A high gate edges");
                compareValue(edgesLow, stim[base+6], "phase B low gate edges");
                while (stepChanges < stim[base+5]) @(posedge clk);
                monEn = 1'b0;
                writeReg(6'h00, 32'd0);
                testsRun++;
                $display("test %0d finished with %0d errors", t, errors - failsBefore);
            end
        end
        $display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
